// File: all.f
+incdir+.
swu_pkg.sv
swu_fill_if.sv
swu_read_if.sv
swu_pixel_writer.sv
swu_window_scan.sv
swu_line_buffer.sv
swu_output_stage.sv
swu_top.sv
tb_swu_top.sv

// File: tb_swu_tests.svh
`ifndef TB_SWU_TESTS_SVH
`define TB_SWU_TESTS_SVH

//////////////////////////////
// stimulus helpers
//////////////////////////////

task automatic apply_reset();
   @(posedge clk);
   resetn     <= 1'b0;
   ip_valid_i <= 1'b0;
   op_ready_i <= 1'b0;
   repeat (4) @(posedge clk);
   resetn <= 1'b1;
endtask

task automatic fill_image(input int slot);
   swu_pkg::word_t w;
   for (int i = 0; i < `SWU_FRAME_WORDS; i++) begin
      for (int b = 0; b < `SWU_WORD_W; b++) begin
         w[b] = next_random_bit();
      end
      img[slot][i] = w;
   end
endtask

// first count words of an image, optionally with random gaps on valid
task automatic send_words(input int slot, input int count, input bit gaps);
   int n;
   n = 0;
   while (n < count) begin
      @(posedge clk);
      if (ip_valid_i && ip_ready_o) begin
         n++;
      end
      if (n < count && !(gaps && next_random_bit())) begin
         ip_valid_i <= 1'b1;
         ip_data_i  <= img[slot][n];
      end else begin
         ip_valid_i <= 1'b0;
      end
   end
endtask

// one frame of results against the model, optionally with random stalls
task automatic receive_frame(input int slot, input bit stalls);
   int j;
   j = 0;
   while (j < `SWU_OUT_WORDS) begin
      @(posedge clk);
      if (op_valid_o && op_ready_i) begin
         compare_word(op_data_o, model_word(slot, j), $sformatf("output beat %0d", j));
         j++;
      end
      op_ready_i <= stalls ? next_random_bit() : 1'b1;
   end
endtask

task automatic report_result(input string name, input int errors_before);
   tests_run++;
   if (error_count == errors_before) begin
      tests_passed++;
      $display("%s: passed", name);
   end else begin
      $display("%s: failed with %0d errors", name, error_count - errors_before);
   end
endtask

//////////////////////////////
// directed tests
//////////////////////////////

task automatic steady_stream();
   int errors_before;
   errors_before = error_count;
   fill_image(0);
   fork
      send_words(0, `SWU_FRAME_WORDS, 1'b0);
      receive_frame(0, 1'b0);
   join
   report_result("steady stream", errors_before);
endtask

task automatic gapped_stream();
   int errors_before;
   errors_before = error_count;
   fill_image(0);
   fork
      send_words(0, `SWU_FRAME_WORDS, 1'b1);
      receive_frame(0, 1'b1);
   join
   report_result("input gaps and output stalls", errors_before);
endtask

task automatic back_to_back_frames();
   int errors_before;
   errors_before = error_count;
   fill_image(0);
   fill_image(1);
   fork
      begin
         send_words(0, `SWU_FRAME_WORDS, 1'b0);
         send_words(1, `SWU_FRAME_WORDS, 1'b0);
      end
      begin
         receive_frame(0, 1'b0);
         receive_frame(1, 1'b0);
      end
   join
   report_result("two frames back to back", errors_before);
endtask

task automatic stalled_output();
   int                  errors_before;
   swu_pkg::frame_idx_t beats_before;
   errors_before = error_count;
   fill_image(0);
   @(posedge clk);
   op_ready_i <= 1'b0;
   beats_before = in_beats;
   fork
      send_words(0, `SWU_FRAME_WORDS, 1'b0);
      begin
         @(posedge clk);
         while (!op_valid_o) begin
            @(posedge clk);
         end
         // first result held until the buffer is full
         while (ip_ready_o) begin
            compare_word(op_data_o, model_word(0, 0), "held output");
            @(posedge clk);
         end
         compare_word(op_data_o, model_word(0, 0), "held output");
         // rd_base is still zero, so admission stops at the buffer depth
         compare_count(swu_pkg::frame_idx_t'(in_beats - beats_before),
                       swu_pkg::frame_idx_t'(`SWU_BUF_DEPTH), "accepted beats");
         receive_frame(0, 1'b0);
      end
   join
   report_result("output held low", errors_before);
endtask

task automatic reset_mid_frame();
   int errors_before;
   errors_before = error_count;
   fill_image(0);
   op_ready_i <= 1'b1;
   send_words(0, `SWU_FRAME_WORDS / 2, 1'b0);
   apply_reset();
   @(posedge clk);
   compare_flag(op_valid_o, 1'b0, "op_valid_o after reset");
   compare_flag(ip_ready_o, 1'b1, "ip_ready_o after reset");
   fill_image(0);
   fork
      send_words(0, `SWU_FRAME_WORDS, 1'b0);
      receive_frame(0, 1'b0);
   join
   report_result("reset mid frame", errors_before);
endtask

`endif

// File: tb_swu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "swu_params.svh"

module tb_swu_top;

   // words moved by all tests, six and a half frames in and six out
   localparam int TIMEOUT_CYCLES =
      8 * (6 * `SWU_FRAME_WORDS + `SWU_FRAME_WORDS / 2 + 6 * `SWU_OUT_WORDS);

   logic           clk;
   logic           resetn;
   swu_pkg::word_t ip_data_i;
   logic           ip_valid_i;
   logic           ip_ready_o;
   swu_pkg::word_t op_data_o;
   logic           op_valid_o;
   logic           op_ready_i;

   // two input images, so back-to-back frames can differ
   swu_pkg::word_t      img [2][`SWU_FRAME_WORDS];
   logic [31:0]         lfsr = 32'h3ff9439d;
   swu_pkg::frame_idx_t in_beats = '0;
   int                  cycles = 0;
   int                  check_count = 0;
   int                  error_count = 0;
   int                  tests_run = 0;
   int                  tests_passed = 0;

   swu_top u_dut (
      .clk        (clk),
      .resetn     (resetn),
      .ip_data_i  (ip_data_i),
      .ip_valid_i (ip_valid_i),
      .ip_ready_o (ip_ready_o),
      .op_data_o  (op_data_o),
      .op_valid_o (op_valid_o),
      .op_ready_i (op_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // accepted input beats, read back at a later edge
   always @(posedge clk) begin
      if (ip_valid_i && ip_ready_o) begin
         in_beats <= in_beats + 1'b1;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   //////////////////////////////
   // random bits and reference model
   //////////////////////////////

   // galois lfsr, x^32 + x^22 + x^2 + x + 1
   function automatic logic next_random_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out) begin
         lfsr = lfsr ^ 32'h80200003;
      end
      return out;
   endfunction

   // beat j of a frame, from its place in the scan order
   function automatic swu_pkg::word_t model_word(input int slot, input int j);
      int pix;
      int pos;
      int orow;
      int ocol;
      int kr;
      int kc;
      int g;
      int idx;
      pix  = j / `SWU_WINDOW_WORDS;
      pos  = j % `SWU_WINDOW_WORDS;
      orow = pix / `SWU_OFM_DIM;
      ocol = pix % `SWU_OFM_DIM;
      kr   = pos / (`SWU_KERNEL_DIM * `SWU_EFF_CH);
      kc   = (pos / `SWU_EFF_CH) % `SWU_KERNEL_DIM;
      g    = pos % `SWU_EFF_CH;
      idx  = (orow * `SWU_STRIDE + kr) * `SWU_IFM_DIM * `SWU_EFF_CH
             + (ocol * `SWU_STRIDE + kc) * `SWU_EFF_CH + g;
      return img[slot][idx];
   endfunction

   //////////////////////////////
   // compare tasks
   //////////////////////////////

   task automatic compare_word(input swu_pkg::word_t got, input swu_pkg::word_t expected,
                               input string what);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, expected);
      end
   endtask

   task automatic compare_count(input swu_pkg::frame_idx_t got,
                                input swu_pkg::frame_idx_t expected, input string what);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, expected);
      end
   endtask

   task automatic compare_flag(input logic got, input logic expected, input string what);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, expected);
      end
   endtask

   `include "tb_swu_tests.svh"

   initial begin
      resetn     = 1'b0;
      ip_data_i  = '0;
      ip_valid_i = 1'b0;
      op_ready_i = 1'b0;
      apply_reset();
      steady_stream();
      gapped_stream();
      back_to_back_frames();
      stalled_output();
      reset_mid_frame();
      $display("%0d of %0d tests passed, %0d checks, %0d errors",
               tests_passed, tests_run, check_count, error_count);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: swu_top.sv
`timescale 1ns/10ps
`default_nettype none

module swu_top (
   input  wire logic           clk,
   input  wire logic           resetn,
   input  wire swu_pkg::word_t ip_data_i,
   input  wire logic           ip_valid_i,
   output logic                ip_ready_o,
   output swu_pkg::word_t      op_data_o,
   output logic                op_valid_o,
   input  wire logic           op_ready_i
);

   // write side of the line buffer
   logic               wr_en;
   swu_pkg::buf_addr_t wr_addr;
   swu_pkg::word_t     wr_data;

   swu_fill_if fill ();
   swu_read_if rd ();

   //////////////////////////////
   // input fill and admission
   //////////////////////////////

   swu_pixel_writer u_writer (
      .clk        (clk),
      .resetn     (resetn),
      .ip_data_i  (ip_data_i),
      .ip_valid_i (ip_valid_i),
      .ip_ready_o (ip_ready_o),
      .fill       (fill),
      .wr_en_o    (wr_en),
      .wr_addr_o  (wr_addr),
      .wr_data_o  (wr_data)
   );

   swu_line_buffer u_buffer (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data),
      .rd        (rd)
   );

   //////////////////////////////
   // window scan and result staging
   //////////////////////////////

   swu_window_scan u_scan (
      .clk    (clk),
      .resetn (resetn),
      .fill   (fill),
      .rd     (rd)
   );

   swu_output_stage u_stage (
      .clk        (clk),
      .resetn     (resetn),
      .rd         (rd),
      .op_data_o  (op_data_o),
      .op_valid_o (op_valid_o),
      .op_ready_i (op_ready_i)
   );

endmodule

`default_nettype wire

// File: swu_output_stage.sv
`timescale 1ns/10ps
`default_nettype none

module swu_output_stage (
   input  wire logic       clk,
   input  wire logic       resetn,
   swu_read_if.stage       rd,
   output swu_pkg::word_t  op_data_o,
   output logic            op_valid_o,
   input  wire logic       op_ready_i
);

   logic           inflight;
   logic           show_valid;
   logic           skid_valid;
   swu_pkg::word_t show_data;
   swu_pkg::word_t skid_data;
   logic           show_free;
   logic [1:0]     occupancy;

   // shown slot empties when it is empty or taken this cycle
   assign show_free = !show_valid || op_ready_i;

   // held words plus the read on its way
   assign occupancy = 2'(show_valid) + 2'(skid_valid) + 2'(inflight);
   assign rd.room   = (occupancy < 2'd2);

   //////////////////////////////
   // slot control
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         inflight   <= 1'b0;
         show_valid <= 1'b0;
         skid_valid <= 1'b0;
      end else begin
         inflight <= rd.rd_en;
         if (show_free) begin
            show_valid <= skid_valid || inflight;
            skid_valid <= skid_valid && inflight;
         end else begin
            skid_valid <= skid_valid || inflight;
         end
      end
   end

   // skid word moves up first, a landing word fills whatever is left
   always_ff @(posedge clk) begin
      if (show_free && (skid_valid || inflight)) begin
         show_data <= skid_valid ? skid_data : rd.rd_data;
      end
      if (inflight && (skid_valid || !show_free)) begin
         skid_data <= rd.rd_data;
      end
   end

   assign op_data_o  = show_data;
   assign op_valid_o = show_valid;

   // a landing word always finds a free slot
   a_no_drop: assert property (@(posedge clk) disable iff (!resetn)
      inflight |-> (show_free || !skid_valid))
      else $error("landing read word found no free slot");

endmodule

`default_nettype wire

// File: swu_line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "swu_params.svh"

module swu_line_buffer (
   input wire logic               clk,
   input wire logic               wr_en_i,
   input wire swu_pkg::buf_addr_t wr_addr_i,
   input wire swu_pkg::word_t     wr_data_i,
   swu_read_if.buffer             rd
);

   // kernel-height rows, used as a ring
   swu_pkg::word_t mem [`SWU_BUF_DEPTH];
   swu_pkg::word_t rd_data_q;

   //////////////////////////////
   // write port
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   //////////////////////////////
   // read port
   //////////////////////////////

   // registered read, holds its value between reads
   always_ff @(posedge clk) begin
      if (rd.rd_en) begin
         rd_data_q <= mem[rd.rd_addr];
      end
   end

   assign rd.rd_data = rd_data_q;

endmodule

`default_nettype wire

// File: swu_window_scan.sv
`timescale 1ns/10ps
`default_nettype none

`include "swu_params.svh"

module swu_window_scan (
   input wire logic clk,
   input wire logic resetn,
   swu_fill_if.scan fill,
   swu_read_if.scan rd
);

   localparam int ROW_WORDS = `SWU_IFM_DIM * `SWU_EFF_CH;
   localparam int ROW_STEP  = `SWU_STRIDE * ROW_WORDS;
   // wide enough for a wrapped base plus an in-window offset
   localparam int SUM_W     = $clog2(2 * `SWU_BUF_DEPTH);

   swu_pkg::scan_state_e state;

   swu_pkg::ofm_cnt_t   orow;
   swu_pkg::ofm_cnt_t   ocol;
   swu_pkg::kern_cnt_t  kr;
   swu_pkg::kern_cnt_t  kc;
   swu_pkg::grp_cnt_t   grp;

   swu_pkg::frame_idx_t rd_base;
   swu_pkg::buf_addr_t  base_addr;
   swu_pkg::frame_idx_t kern_off;
   swu_pkg::frame_idx_t rd_idx;

   logic last_grp;
   logic last_kc;
   logic last_kr;
   logic last_ocol;
   logic last_orow;
   logic last_read;

   // single compare and subtract, the sum never reaches twice the depth
   function automatic swu_pkg::buf_addr_t wrap_addr(input logic [SUM_W-1:0] sum);
      if (sum >= SUM_W'(`SWU_BUF_DEPTH)) begin
         return swu_pkg::buf_addr_t'(sum - SUM_W'(`SWU_BUF_DEPTH));
      end
      return swu_pkg::buf_addr_t'(sum);
   endfunction

   //////////////////////////////
   // read index and address
   //////////////////////////////

   // offset of the current word from the top row of the output row
   assign kern_off = swu_pkg::frame_idx_t'(kr * ROW_WORDS
                     + (ocol * `SWU_STRIDE + kc) * `SWU_EFF_CH + grp);
   assign rd_idx   = rd_base + kern_off;

   assign rd.rd_addr = wrap_addr(SUM_W'(base_addr) + SUM_W'(kern_off));

   // word must already be in the buffer and the stage must have room
   assign rd.rd_en = (state == swu_pkg::SCAN_RUN) && rd.room && (rd_idx < fill.wr_count);

   assign last_grp  = (grp == `SWU_EFF_CH - 1);
   assign last_kc   = (kc == `SWU_KERNEL_DIM - 1);
   assign last_kr   = (kr == `SWU_KERNEL_DIM - 1);
   assign last_ocol = (ocol == `SWU_OFM_DIM - 1);
   assign last_orow = (orow == `SWU_OFM_DIM - 1);
   assign last_read = rd.rd_en && last_grp && last_kc && last_kr && last_ocol && last_orow;

   assign fill.rd_base   = rd_base;
   assign fill.frame_end = (state == swu_pkg::SCAN_DONE) && fill.frame_loaded;

   //////////////////////////////
   // window counters
   //////////////////////////////

   // order is group, kernel column, kernel row, output column, output row
   always_ff @(posedge clk) begin
      if (!resetn || fill.frame_end) begin
         grp       <= '0;
         kc        <= '0;
         kr        <= '0;
         ocol      <= '0;
         orow      <= '0;
         rd_base   <= '0;
         base_addr <= '0;
      end else if (rd.rd_en) begin
         grp <= last_grp ? '0 : grp + 1'b1;
         if (last_grp) begin
            kc <= last_kc ? '0 : kc + 1'b1;
            if (last_kc) begin
               kr <= last_kr ? '0 : kr + 1'b1;
               if (last_kr) begin
                  ocol <= last_ocol ? '0 : ocol + 1'b1;
                  // new output row frees STRIDE input rows
                  if (last_ocol && !last_orow) begin
                     orow      <= orow + 1'b1;
                     rd_base   <= rd_base + swu_pkg::frame_idx_t'(ROW_STEP);
                     base_addr <= wrap_addr(SUM_W'(base_addr) + SUM_W'(ROW_STEP));
                  end else if (last_ocol) begin
                     orow <= '0;
                  end
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state <= swu_pkg::SCAN_IDLE;
      end else begin
         case (state)
            swu_pkg::SCAN_IDLE: begin
               if (fill.wr_count != '0) begin
                  state <= swu_pkg::SCAN_RUN;
               end
            end
            swu_pkg::SCAN_RUN: begin
               if (last_read) begin
                  state <= swu_pkg::SCAN_DONE;
               end
            end
            swu_pkg::SCAN_DONE: begin
               if (fill.frame_end) begin
                  state <= swu_pkg::SCAN_IDLE;
               end
            end
            default: state <= swu_pkg::SCAN_IDLE;
         endcase
      end
   end

   // word read is still in the ring and sits at its index modulo the depth
   a_read_live: assert property (@(posedge clk) disable iff (!resetn)
      rd.rd_en |-> (fill.wr_count - rd_idx <= swu_pkg::frame_idx_t'(`SWU_BUF_DEPTH))
                   && (rd.rd_addr == swu_pkg::buf_addr_t'(rd_idx % `SWU_BUF_DEPTH)))
      else $error("read outside the live part of the buffer");

endmodule

`default_nettype wire

// File: swu_pixel_writer.sv
`timescale 1ns/10ps
`default_nettype none

`include "swu_params.svh"

module swu_pixel_writer (
   input  wire logic           clk,
   input  wire logic           resetn,
   input  wire swu_pkg::word_t ip_data_i,
   input  wire logic           ip_valid_i,
   output logic                ip_ready_o,
   swu_fill_if.writer          fill,
   output logic                wr_en_o,
   output swu_pkg::buf_addr_t  wr_addr_o,
   output swu_pkg::word_t      wr_data_o
);

   swu_pkg::fill_state_e state;
   swu_pkg::frame_idx_t  wr_count;
   swu_pkg::buf_addr_t   wr_addr;
   swu_pkg::frame_idx_t  occupancy;
   logic                 ip_hs;

   // words held that a window may still read
   assign occupancy = wr_count - fill.rd_base;

   // admission stops once the oldest needed word would be overwritten
   assign ip_ready_o = (state == swu_pkg::FILL_RUN) && (occupancy < `SWU_BUF_DEPTH);
   assign ip_hs      = ip_valid_i && ip_ready_o;

   // write goes out on the same edge as the handshake
   assign wr_en_o   = ip_hs;
   assign wr_addr_o = wr_addr;
   assign wr_data_o = ip_data_i;

   assign fill.wr_count     = wr_count;
   assign fill.frame_loaded = (state == swu_pkg::FILL_HOLD);

   //////////////////////////////
   // write pointer and state
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || fill.frame_end) begin
         state    <= swu_pkg::FILL_RUN;
         wr_count <= '0;
         wr_addr  <= '0;
      end else if (ip_hs) begin
         wr_count <= wr_count + 1'b1;
         // circular address
         if (wr_addr == `SWU_BUF_DEPTH - 1) begin
            wr_addr <= '0;
         end else begin
            wr_addr <= wr_addr + 1'b1;
         end
         if (wr_count == `SWU_FRAME_WORDS - 1) begin
            state <= swu_pkg::FILL_HOLD;
         end
      end
   end

   // ring pointer stays in step with the frame index of the word written
   a_addr_in_step: assert property (@(posedge clk) disable iff (!resetn)
      wr_en_o |-> (wr_addr_o == swu_pkg::buf_addr_t'(wr_count % `SWU_BUF_DEPTH)))
      else $error("write address out of step with the write count");

endmodule

`default_nettype wire

// File: swu_read_if.sv
`timescale 1ns/10ps
`default_nettype none

// buffer read path, from the scan through the buffer into the stage
interface swu_read_if;

   // read strobe and address from the scan
   logic rd_en;
   swu_pkg::buf_addr_t rd_addr;
   // registered read data, one cycle after rd_en
   swu_pkg::word_t rd_data;
   // stage can take one more word
   logic room;

   modport scan (
      output rd_en,
      output rd_addr,
      input  room
   );

   modport buffer (
      input  rd_en,
      input  rd_addr,
      output rd_data
   );

   modport stage (
      input  rd_en,
      input  rd_data,
      output room
   );

endinterface

`default_nettype wire

// File: swu_fill_if.sv
`timescale 1ns/10ps
`default_nettype none

// fill progress between the pixel writer and the window scan
interface swu_fill_if;

   // words written so far in this frame
   swu_pkg::frame_idx_t wr_count;
   // lowest frame index any remaining window still reads
   swu_pkg::frame_idx_t rd_base;
   // single-cycle restart of both sides
   logic frame_end;
   // whole frame is in the buffer
   logic frame_loaded;

   modport writer (
      output wr_count,
      output frame_loaded,
      input  rd_base,
      input  frame_end
   );

   modport scan (
      input  wr_count,
      input  frame_loaded,
      output rd_base,
      output frame_end
   );

endinterface

`default_nettype wire

// File: swu_pkg.sv
`default_nettype none

`include "swu_params.svh"

package swu_pkg;

   //////////////////////////////
   // data and index types
   //////////////////////////////

   // one beat on either stream
   typedef logic [`SWU_WORD_W-1:0] word_t;

   // line buffer address
   typedef logic [$clog2(`SWU_BUF_DEPTH)-1:0] buf_addr_t;

   // position of a word in the frame, also holds the full-frame count
   typedef logic [$clog2(`SWU_FRAME_WORDS + 1)-1:0] frame_idx_t;

   // scan counters
   typedef logic [$clog2(`SWU_OFM_DIM + 1)-1:0] ofm_cnt_t;
   typedef logic [$clog2(`SWU_KERNEL_DIM + 1)-1:0] kern_cnt_t;
   typedef logic [$clog2(`SWU_EFF_CH + 1)-1:0] grp_cnt_t;

   //////////////////////////////
   // state machines
   //////////////////////////////

   // writer: accepting beats, or frame complete and waiting for the restart
   typedef enum logic [0:0] {
      FILL_RUN,
      FILL_HOLD
   } fill_state_e;

   // scan: nothing written yet, issuing reads, last read in flight
   typedef enum logic [1:0] {
      SCAN_IDLE,
      SCAN_RUN,
      SCAN_DONE
   } scan_state_e;

endpackage

`default_nettype wire

// File: swu_params.svh
`ifndef SWU_PARAMS_SVH
`define SWU_PARAMS_SVH

//////////////////////////////
// stream word
//////////////////////////////

// lanes per beat and bits per lane
`define SWU_SIMD         4
`define SWU_PREC         2
`define SWU_WORD_W       (`SWU_SIMD * `SWU_PREC)

//////////////////////////////
// geometry
//////////////////////////////

`define SWU_CHANNELS     8
// channel groups, one beat each
`define SWU_EFF_CH       (`SWU_CHANNELS / `SWU_SIMD)
`define SWU_IFM_DIM      5
`define SWU_KERNEL_DIM   3
`define SWU_STRIDE       1
`define SWU_OFM_DIM      (((`SWU_IFM_DIM - `SWU_KERNEL_DIM) / `SWU_STRIDE) + 1)

// derived counts per frame
`define SWU_FRAME_WORDS  (`SWU_IFM_DIM * `SWU_IFM_DIM * `SWU_EFF_CH)
`define SWU_WINDOW_WORDS (`SWU_KERNEL_DIM * `SWU_KERNEL_DIM * `SWU_EFF_CH)
`define SWU_OUT_WORDS    (`SWU_OFM_DIM * `SWU_OFM_DIM * `SWU_WINDOW_WORDS)
// kernel-height rows of input words
`define SWU_BUF_DEPTH    (`SWU_KERNEL_DIM * `SWU_IFM_DIM * `SWU_EFF_CH)

`endif
